/* hw/tracer_pkg.sv */
// shared widths, opcode and class encodings and record types for the instruction trace unit
`default_nettype none

package tracer_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 5;
  localparam int unsigned cycle_w    = 32;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  // RV32I major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    opc_lui      = 7'b0110111,
    opc_auipc    = 7'b0010111,
    opc_jal      = 7'b1101111,
    opc_jalr     = 7'b1100111,
    opc_branch   = 7'b1100011,
    opc_load     = 7'b0000011,
    opc_store    = 7'b0100011,
    opc_op_imm   = 7'b0010011,
    opc_op       = 7'b0110011,
    opc_misc_mem = 7'b0001111,
    opc_system   = 7'b1110011
  } opcode_e;

  // class reported in the trace record
  typedef enum logic [3:0] {
    cls_lui     = 4'd0,
    cls_auipc   = 4'd1,
    cls_jal     = 4'd2,
    cls_jalr    = 4'd3,
    cls_branch  = 4'd4,
    cls_load    = 4'd5,
    cls_store   = 4'd6,
    cls_op_imm  = 4'd7,
    cls_op      = 4'd8,
    cls_fence   = 4'd9,
    cls_system  = 4'd10,
    cls_invalid = 4'd11
  } instr_class_e;

  //////////////////////////////////////////////////
  // port and record types
  //////////////////////////////////////////////////

  // one register file write port of the core
  typedef struct packed {
    logic                  we;
    logic [reg_addr_w-1:0] addr;
    logic [xlen-1:0]       wdata;
  } reg_write_t;

  // one data bus request, write data is not traced
  typedef struct packed {
    logic            req;
    logic            gnt;
    logic            we;
    logic [xlen-1:0] addr;
  } data_access_t;

  typedef struct packed {
    logic [cycle_w-1:0]    cycle;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       instr;
    instr_class_e          cls;
    // destination, value follows the core's writes
    logic [reg_addr_w-1:0] rd;
    logic                  rd_we;
    logic [xlen-1:0]       rd_value;
    // sources as read at issue
    logic [reg_addr_w-1:0] rs1;
    logic [xlen-1:0]       rs1_value;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       rs2_value;
    // first granted data access
    logic                  mem_valid;
    logic                  mem_we;
    logic [xlen-1:0]       mem_addr;
  } trace_rec_t;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // replace rd_value when the write hits the traced destination
  function automatic trace_rec_t capture_rd(trace_rec_t rec, reg_write_t wr);
    trace_rec_t res;
    res = rec;
    if (rec.rd_we && wr.we && (wr.addr == rec.rd)) begin
      res.rd_value = wr.wdata;
    end
    return res;
  endfunction

endpackage

`default_nettype wire

/* hw/trace_issue.sv */
// issue stage of the tracer: classifies each issued instruction and registers its record
`default_nettype none

module trace_issue (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         id_valid,
  input  logic                         is_decoding,
  input  logic                         ecall,
  input  logic                         ebreak,
  input  logic                         mret,
  input  logic [tracer_pkg::xlen-1:0]  pc,
  input  logic [tracer_pkg::xlen-1:0]  instr,
  input  logic [tracer_pkg::xlen-1:0]  rs1_value,
  input  logic [tracer_pkg::xlen-1:0]  rs2_value,
  output logic                         issue_load,
  output tracer_pkg::trace_rec_t       issue_rec
);

  import tracer_pkg::*;

  logic [cycle_w-1:0]    cycle_q;
  logic                  issue;
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [reg_addr_w-1:0] rd_idx;
  logic [reg_addr_w-1:0] rs1_idx;
  logic [reg_addr_w-1:0] rs2_idx;
  instr_class_e          cls;
  logic                  uses_rd;
  logic                  uses_rs1;
  logic                  uses_rs2;
  trace_rec_t            rec_d;

  // free-running cycle stamp
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + cycle_w'(1);
    end
  end

  // system instructions issue even without id_valid
  assign issue = is_decoding && (id_valid || ecall || ebreak || mret);

  assign opcode  = opcode_e'(instr[6:0]);
  assign funct3  = instr[14:12];
  assign rd_idx  = instr[11:7];
  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];

  //////////////////////////////////////////////////
  // class and register use
  //////////////////////////////////////////////////

  always_comb begin
    cls      = cls_invalid;
    uses_rd  = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      opc_lui: begin
        cls     = cls_lui;
        uses_rd = 1'b1;
      end
      opc_auipc: begin
        cls     = cls_auipc;
        uses_rd = 1'b1;
      end
      opc_jal: begin
        cls     = cls_jal;
        uses_rd = 1'b1;
      end
      opc_jalr: begin
        cls      = cls_jalr;
        uses_rd  = 1'b1;
        uses_rs1 = 1'b1;
      end
      opc_branch: begin
        cls      = cls_branch;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      opc_load: begin
        cls      = cls_load;
        uses_rd  = 1'b1;
        uses_rs1 = 1'b1;
      end
      opc_store: begin
        cls      = cls_store;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      opc_op_imm: begin
        cls      = cls_op_imm;
        uses_rd  = 1'b1;
        uses_rs1 = 1'b1;
      end
      opc_op: begin
        cls      = cls_op;
        uses_rd  = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      opc_misc_mem: begin
        cls = cls_fence;
      end
      opc_system: begin
        cls      = cls_system;
        // csr forms only, the immediate forms take no rs1
        uses_rd  = (funct3 != 3'b000);
        uses_rs1 = (funct3 != 3'b000) && !funct3[2];
      end
      default: begin
        cls = cls_invalid;
      end
    endcase
  end

  // unused indices and values are reported as zero
  always_comb begin
    rec_d           = '0;
    rec_d.cycle     = cycle_q;
    rec_d.pc        = pc;
    rec_d.instr     = instr;
    rec_d.cls       = cls;
    rec_d.rd        = uses_rd ? rd_idx : '0;
    rec_d.rd_we     = uses_rd && (rd_idx != '0);
    rec_d.rs1       = uses_rs1 ? rs1_idx : '0;
    rec_d.rs1_value = uses_rs1 ? rs1_value : '0;
    rec_d.rs2       = uses_rs2 ? rs2_idx : '0;
    rec_d.rs2_value = uses_rs2 ? rs2_value : '0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_load <= 1'b0;
    end else begin
      issue_load <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      issue_rec <= rec_d;
    end
  end

  // an unknown decode strobe would silently drop or invent records
  a_decoding_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(is_decoding)
  ) else $error("is_decoding is unknown");

endmodule

`default_nettype wire

/* hw/trace_ex_stage.sv */
// EX tracking slot: holds one record while the core executes it and logs EX writes and accesses
`default_nettype none

module trace_ex_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         issue_load,
  input  tracer_pkg::trace_rec_t       issue_rec,
  input  logic                         ex_valid,
  input  tracer_pkg::reg_write_t       ex_write,
  input  tracer_pkg::data_access_t     ex_data,
  output logic                         ex_done,
  output tracer_pkg::trace_rec_t       ex_rec
);

  import tracer_pkg::*;

  logic       occupied_q;
  trace_rec_t rec_q;
  trace_rec_t rec_upd;

  // record including this cycle's write and access
  always_comb begin
    rec_upd = capture_rd(rec_q, ex_write);
    if (!rec_q.mem_valid && ex_data.req && ex_data.gnt) begin
      rec_upd.mem_valid = 1'b1;
      rec_upd.mem_we    = ex_data.we;
      rec_upd.mem_addr  = ex_data.addr;
    end
  end

  assign ex_done = occupied_q && ex_valid;
  assign ex_rec  = rec_upd;

  //////////////////////////////////////////////////
  // slot state
  //////////////////////////////////////////////////

  // a new issue may refill the slot on the edge it empties
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occupied_q <= 1'b0;
    end else begin
      occupied_q <= issue_load || (occupied_q && !ex_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (issue_load) begin
      rec_q <= issue_rec;
    end else if (occupied_q) begin
      rec_q <= rec_upd;
    end
  end

  // core must not issue into a slot that is still busy
  a_ex_overrun: assert property (
    @(posedge clk) disable iff (!rst_n) issue_load |-> (!occupied_q || ex_valid)
  ) else $error("issue into occupied EX slot");

endmodule

`default_nettype wire

/* hw/trace_wb_stage.sv */
// WB tracking slot: holds one record until write-back and passes it to the output register
`default_nettype none

module trace_wb_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         ex_done,
  input  tracer_pkg::trace_rec_t       ex_rec,
  input  logic                         wb_valid,
  input  tracer_pkg::reg_write_t       wb_write,
  output logic                         wb_done,
  output tracer_pkg::trace_rec_t       wb_rec
);

  import tracer_pkg::*;

  logic       occupied_q;
  trace_rec_t rec_q;
  trace_rec_t rec_upd;

  // wb value overrides whatever EX saw
  assign rec_upd = capture_rd(rec_q, wb_write);

  assign wb_done = occupied_q && wb_valid;
  assign wb_rec  = rec_upd;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occupied_q <= 1'b0;
    end else begin
      occupied_q <= ex_done || (occupied_q && !wb_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (ex_done) begin
      rec_q <= ex_rec;
    end else if (occupied_q) begin
      rec_q <= rec_upd;
    end
  end

  // EX may only hand over when WB is free or leaving
  a_wb_overrun: assert property (
    @(posedge clk) disable iff (!rst_n) ex_done |-> (!occupied_q || wb_valid)
  ) else $error("EX record into occupied WB slot");

endmodule

`default_nettype wire

/* hw/trace_emit.sv */
// trace output register: presents each finished record with a one-cycle valid and counts them
`default_nettype none

module trace_emit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wb_done,
  input  tracer_pkg::trace_rec_t         wb_rec,
  output logic                           trace_valid,
  output tracer_pkg::trace_rec_t         trace,
  output logic [tracer_pkg::cycle_w-1:0] retired_count
);

  import tracer_pkg::*;

  //////////////////////////////////////////////////
  // valid pulse and retire counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_valid   <= 1'b0;
      retired_count <= '0;
    end else begin
      trace_valid <= wb_done;
      if (wb_done) begin
        retired_count <= retired_count + cycle_w'(1);
      end
    end
  end

  // record stays on the port until the next one
  always_ff @(posedge clk) begin
    if (wb_done) begin
      trace <= wb_rec;
    end
  end

  // one record per pulse, never a held level
  a_valid_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) trace_valid |=> !trace_valid
  ) else $error("trace_valid high for two cycles");

endmodule

`default_nettype wire

/* hw/instr_tracer.sv */
// top level of the instruction trace unit, chains issue, EX, WB and output stages
`default_nettype none

module instr_tracer (
  input  logic                           clk,
  input  logic                           rst_n,
  // issue strobes
  input  logic                           id_valid,
  input  logic                           is_decoding,
  input  logic                           ecall,
  input  logic                           ebreak,
  input  logic                           mret,
  input  logic [tracer_pkg::xlen-1:0]    pc,
  input  logic [tracer_pkg::xlen-1:0]    instr,
  input  logic [tracer_pkg::xlen-1:0]    rs1_value,
  input  logic [tracer_pkg::xlen-1:0]    rs2_value,
  // execute stage
  input  logic                           ex_valid,
  input  tracer_pkg::reg_write_t         ex_write,
  input  tracer_pkg::data_access_t       ex_data,
  // write-back stage
  input  logic                           wb_valid,
  input  tracer_pkg::reg_write_t         wb_write,
  // trace port
  output logic                           trace_valid,
  output tracer_pkg::trace_rec_t         trace,
  output logic [tracer_pkg::cycle_w-1:0] retired_count
);

  import tracer_pkg::*;

  logic       issue_load;
  trace_rec_t issue_rec;
  logic       ex_done;
  trace_rec_t ex_rec;
  logic       wb_done;
  trace_rec_t wb_rec;

  trace_issue issue_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .id_valid    (id_valid),
    .is_decoding (is_decoding),
    .ecall       (ecall),
    .ebreak      (ebreak),
    .mret        (mret),
    .pc          (pc),
    .instr       (instr),
    .rs1_value   (rs1_value),
    .rs2_value   (rs2_value),
    .issue_load  (issue_load),
    .issue_rec   (issue_rec)
  );

  trace_ex_stage ex_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue_load (issue_load),
    .issue_rec  (issue_rec),
    .ex_valid   (ex_valid),
    .ex_write   (ex_write),
    .ex_data    (ex_data),
    .ex_done    (ex_done),
    .ex_rec     (ex_rec)
  );

  trace_wb_stage wb_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ex_done  (ex_done),
    .ex_rec   (ex_rec),
    .wb_valid (wb_valid),
    .wb_write (wb_write),
    .wb_done  (wb_done),
    .wb_rec   (wb_rec)
  );

  trace_emit emit_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_done       (wb_done),
    .wb_rec        (wb_rec),
    .trace_valid   (trace_valid),
    .trace         (trace),
    .retired_count (retired_count)
  );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
// testbench clock and reset source, instantiated once by the trace unit testbench
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int half_period = 50;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // reset held for the first 5 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* dv/instr_tracer_tb.sv */
// testbench for the trace unit: applies a table of instructions and checks every trace record
`default_nettype none

module instr_tracer_tb;

  import tracer_pkg::*;

  typedef struct {
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
    reg_write_t      ex_write;
    data_access_t    ex_data;
    reg_write_t      wb_write;
    int              ex_delay;
    int              wb_delay;
    bit              overlap;
    int              kind;
    instr_class_e    exp_cls;
    bit              exp_rd_we;
  } test_row_t;

  localparam reg_write_t   wr_none  = '0;
  localparam data_access_t acc_none = '0;

  logic clk, rst_n;
  logic id_valid, is_decoding, ecall, ebreak, mret, ex_valid, wb_valid;
  logic [xlen-1:0] pc, instr, rs1_value, rs2_value;
  reg_write_t ex_write, wb_write;
  data_access_t ex_data;
  logic trace_valid;
  trace_rec_t trace;
  logic [cycle_w-1:0] retired_count;

  test_row_t rows[32];
  logic [xlen-1:0] rs1_vals[32];
  logic [xlen-1:0] rs2_vals[32];
  logic [cycle_w-1:0] issue_cycles[$];
  logic [cycle_w-1:0] edge_cnt;
  integer seed = 35;
  int n_rows = 0;
  int checks = 0;
  int errors = 0;
  int records = 0;

  tb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  instr_tracer dut_i (.*);

  // edge count since reset sampled on each issue edge for the cycle stamp
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edge_cnt <= '0;
    end else begin
      if (is_decoding && (id_valid || ecall || ebreak || mret)) begin
        issue_cycles.push_back(edge_cnt);
      end
      edge_cnt <= edge_cnt + 1;
    end
  end

  initial begin
    @(posedge rst_n);
    repeat (n_rows * 20 + 10) @(posedge clk);
    $display("timeout: the test sequence did not complete in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic reg_write_t wr(logic we, logic [4:0] addr, logic [31:0] data);
    return '{we, addr, data};
  endfunction

  function automatic data_access_t acc(logic req, logic gnt, logic we, logic [31:0] addr);
    return '{req, gnt, we, addr};
  endfunction

  function automatic void add_row(logic [31:0] instr_w, reg_write_t exw, data_access_t exd,
                                  reg_write_t wbw, int exd_l, int wbd_l, bit ovl, int kind,
                                  instr_class_e cls, bit rd_we);
    rows[n_rows] = '{instr_w, 32'h1000 + 4 * n_rows, exw, exd, wbw, exd_l, wbd_l, ovl, kind,
                     cls, rd_we};
    n_rows++;
  endfunction

  ////////////////////////////////////////////////////
  // expected record from the register-use rules
  ////////////////////////////////////////////////////

  function automatic trace_rec_t expect_rec(test_row_t r, logic [31:0] v1, logic [31:0] v2,
                                            logic [cycle_w-1:0] cyc);
    trace_rec_t e;
    logic [2:0] f3;
    logic rd_u, rs1_u, rs2_u;
    e = '0;
    f3 = r.instr[14:12];
    rd_u = 1'b0;
    rs1_u = 1'b0;
    rs2_u = 1'b0;
    case (r.instr[6:0])
      opc_lui, opc_auipc, opc_jal: rd_u = 1'b1;
      opc_jalr, opc_load, opc_op_imm: {rd_u, rs1_u} = 2'b11;
      opc_branch, opc_store: {rs1_u, rs2_u} = 2'b11;
      opc_op: {rd_u, rs1_u, rs2_u} = 3'b111;
      opc_system: {rd_u, rs1_u} = {f3 != 3'b000, f3 != 3'b000 && !f3[2]};
      default: rd_u = 1'b0;
    endcase
    e.cycle = cyc;
    e.pc = r.pc;
    e.instr = r.instr;
    e.cls = r.exp_cls;
    e.rd = rd_u ? r.instr[11:7] : 5'd0;
    e.rd_we = r.exp_rd_we;
    e.rs1 = rs1_u ? r.instr[19:15] : 5'd0;
    e.rs1_value = rs1_u ? v1 : 32'd0;
    e.rs2 = rs2_u ? r.instr[24:20] : 5'd0;
    e.rs2_value = rs2_u ? v2 : 32'd0;
    // wb write lands last so it wins over the EX value
    if (e.rd_we && r.ex_write.we && r.ex_write.addr == e.rd) e.rd_value = r.ex_write.wdata;
    if (e.rd_we && r.wb_write.we && r.wb_write.addr == e.rd) e.rd_value = r.wb_write.wdata;
    if (r.ex_data.req && r.ex_data.gnt) begin
      e.mem_valid = 1'b1;
      e.mem_we = r.ex_data.we;
      e.mem_addr = r.ex_data.addr;
    end
    return e;
  endfunction

  task automatic check_rec(input trace_rec_t got, input trace_rec_t exp, input int t);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: test %0d record got %h expected %h", $time, t, got, exp);
    end
  endtask

  task automatic check_count(input logic [cycle_w-1:0] got, input logic [cycle_w-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: retired_count got %0d expected %0d", $time, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////
  // pipeline phases, each starts and ends on a rising edge
  ////////////////////////////////////////////////////

  task automatic issue_phase(input int i);
    rs1_vals[i] = $random(seed);
    rs2_vals[i] = $random(seed);
    instr <= rows[i].instr;
    pc <= rows[i].pc;
    rs1_value <= rs1_vals[i];
    rs2_value <= rs2_vals[i];
    is_decoding <= (rows[i].kind != 2);
    id_valid <= (rows[i].kind != 1);
    ecall <= (rows[i].kind == 1);
    @(posedge clk);
    is_decoding <= 1'b0;
    id_valid <= 1'b0;
    ecall <= 1'b0;
    @(posedge clk);
  endtask

  task automatic ex_phase(input int i);
    data_access_t first;
    first = rows[i].ex_data;
    ex_write <= rows[i].ex_write;
    ex_data <= first;
    @(posedge clk);
    // a later granted access must not replace the first one
    ex_data <= (first.req && first.gnt) ? acc(1, 1, !first.we, first.addr + 'h40) : acc_none;
    repeat (rows[i].ex_delay) @(posedge clk);
    ex_valid <= 1'b1;
    @(posedge clk);
    ex_valid <= 1'b0;
    ex_write <= wr_none;
    ex_data <= acc_none;
  endtask

  task automatic wb_phase(input int i);
    wb_write <= rows[i].wb_write;
    repeat (rows[i].wb_delay) @(posedge clk);
    wb_valid <= 1'b1;
    @(posedge clk);
    wb_valid <= 1'b0;
    wb_write <= wr_none;
  endtask

  task automatic finish_row(input int i);
    bit found;
    int err_before;
    logic [cycle_w-1:0] cyc;
    found = 1'b0;
    err_before = errors;
    cyc = (issue_cycles.size() > 0) ? issue_cycles.pop_front() : '0;
    for (int k = 0; k < 3 && !found; k++) begin
      @(negedge clk);
      found = trace_valid;
    end
    if (!found) begin
      errors++;
      $display("test %0d: no trace_valid pulse after write-back", i);
    end else begin
      records++;
      check_rec(trace, expect_rec(rows[i], rs1_vals[i], rs2_vals[i], cyc), i);
      check_count(retired_count, records);
    end
    $display("test %0d %s: %s", i, rows[i].exp_cls.name(), errors == err_before ? "ok" : "failed");
    @(posedge clk);
  endtask

  task automatic check_quiet(input int i);
    int err_before;
    err_before = errors;
    repeat (5) begin
      @(negedge clk);
      if (trace_valid) begin
        errors++;
        $display("test %0d: trace_valid rose although no instruction issued", i);
      end
    end
    check_count(retired_count, records);
    $display("test %0d no issue: %s", i, errors == err_before ? "ok" : "failed");
    @(posedge clk);
  endtask

  initial begin
    int i;
    {id_valid, is_decoding, ecall, ebreak, mret, ex_valid, wb_valid} = '0;
    {pc, instr, rs1_value, rs2_value} = '0;
    ex_write = wr_none;
    wb_write = wr_none;
    ex_data = acc_none;
    // instr, ex write, ex access, wb write, ex delay, wb delay, overlap, kind, class, rd_we
    // kind 0 id_valid, 1 ecall alone, 2 id_valid without is_decoding
    add_row(32'h12345537, wr(1,10,'h12345000), acc_none, wr(1,11,'h99), 0,0,0,0, cls_lui,1);
    add_row(32'h00001297, wr_none, acc(1,0,1,'h200), wr(1,5,'h1a0), 1,1,0,0, cls_auipc,1);
    add_row(32'h0080006f, wr_none, acc_none, wr(1,0,'hdead), 0,0,0,0, cls_jal,0);
    add_row(32'h000300e7, wr(1,1,'h1004), acc_none, wr_none, 0,1,0,0, cls_jalr,1);
    add_row(32'h00838463, wr(1,8,'h31), acc_none, wr_none, 1,0,0,0, cls_branch,0);
    add_row(32'h0044a603, wr_none, acc(1,1,0,'h2000), wr(1,12,'hcafe), 2,0,0,0, cls_load,1);
    add_row(32'h00e6a423, wr_none, acc(1,1,1,'h3004), wr_none, 1,0,0,0, cls_store,0);
    add_row(32'h00158593, wr(1,12,'h55), acc_none, wr(0,11,'h66), 0,0,0,0, cls_op_imm,1);
    add_row(32'h011807b3, wr(1,15,'h1234), acc_none, wr(1,15,'h5678), 1,2,0,0, cls_op,1);
    add_row(32'h0ff0000f, wr_none, acc_none, wr_none, 0,0,0,0, cls_fence,0);
    add_row(32'h34099973, wr_none, acc_none, wr(1,18,'h800), 0,0,0,0, cls_system,1);
    add_row(32'h3402da73, wr(1,20,'h77), acc_none, wr_none, 0,0,0,0, cls_system,1);
    add_row(32'hffffffff, wr_none, acc_none, wr(1,31,'h99), 0,0,0,0, cls_invalid,0);
    add_row(32'h00000073, wr_none, acc_none, wr_none, 0,0,0,1, cls_system,0);
    add_row(32'h00100093, wr_none, acc_none, wr_none, 0,0,0,2, cls_op_imm,1);
    add_row(32'h007302b3, wr(1,5,'haa), acc_none, wr(1,5,'hbb), 0,1,1,0, cls_op,1);
    add_row(32'h00328313, wr(1,6,'hcc), acc_none, wr_none, 1,0,0,0, cls_op_imm,1);
    wait (rst_n);
    @(posedge clk);
    i = 0;
    while (i < n_rows) begin
      if (rows[i].kind == 2) begin
        issue_phase(i);
        check_quiet(i);
        i++;
      end else if (rows[i].overlap && i + 1 < n_rows) begin
        // next instruction issues while this one sits in WB
        issue_phase(i);
        ex_phase(i);
        issue_phase(i + 1);
        wb_phase(i);
        finish_row(i);
        ex_phase(i + 1);
        wb_phase(i + 1);
        finish_row(i + 1);
        i += 2;
      end else begin
        issue_phase(i);
        ex_phase(i);
        wb_phase(i);
        finish_row(i);
        i++;
      end
    end
    $display("%0d tests, %0d checks, %0d errors", n_rows, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hw/tracer_pkg.sv
hw/trace_issue.sv
hw/trace_ex_stage.sv
hw/trace_wb_stage.sv
hw/trace_emit.sv
hw/instr_tracer.sv
dv/tb_clk_gen.sv
dv/instr_tracer_tb.sv
